//--- verilog/sdram_defines.svh
// SDRAM Init Constants
`ifndef SDRAM_DEFINES_SVH
`define SDRAM_DEFINES_SVH

//////////////////////////////////////////////////
// timing
//////////////////////////////////////////////////
`define POWER_UP_CYCLES 8        // power-up hold in clocks for simulation
`define REFRESH_WINDOW 39        // bounds the initial refresh loop
`define TIMER_WIDTH 16           // down-counter width

//////////////////////////////////////////////////
// device geometry
//////////////////////////////////////////////////
`define ROW_WIDTH 13             // A12 to A0
`define BANK_WIDTH 2             // BA1 and BA0

//////////////////////////////////////////////////
// mode register
//////////////////////////////////////////////////
`define MODE_CAS_LATENCY 2       // two clocks
`define MODE_BURST_LENGTH 0      // one word per access
`define MODE_BURST_TYPE 0        // sequential
`define MODE_WRITE_BURST 1       // single-location writes

`define PRECHARGE_ALL_BIT 10     // A10 selects all banks

`endif

//--- verilog/SdramPkg.sv
// SDRAM Init Types
`default_nettype none

`include "sdram_defines.svh"

package SdramPkg;

	// commands the sequencer can ask for
	typedef enum logic [2:0] {
		CmdPowerUp,                          // cke and cs held low
		CmdNop,
		CmdPrechargeAll,
		CmdAutoRefresh,
		CmdModeSet
	} cmdKind_t;

	// pin levels in bus order
	typedef struct packed {
		logic cke;                           // clock enable, active high
		logic csL;
		logic rasL;
		logic casL;
		logic weL;
	} sdramCmd_t;

	// mode register layout on A12 down to A0
	typedef struct packed {
		logic [2:0] reserved;                // A12 to A10 held zero
		logic       writeBurst;              // A9
		logic [1:0] opMode;                  // A8 and A7
		logic [2:0] casLatency;              // A6 to A4
		logic       burstType;               // A3
		logic [2:0] burstLength;             // A2 to A0
	} modeWord_t;

	// the same address pins seen as a row word or a mode word
	typedef union packed {
		logic [`ROW_WIDTH-1:0] row;
		modeWord_t             mode;
	} sdramAddr_u;

	typedef struct packed {
		sdramCmd_t              cmd;
		logic [`BANK_WIDTH-1:0] ba;
		sdramAddr_u             addr;
	} sdramBus_t;

	typedef enum logic [3:0] {
		StInitialising,
		StWaitPowerUp,
		StFirstNop,
		StPrechargeAll,
		StSecondNop,
		StRefresh,
		StRefreshNopA,
		StRefreshNopB,
		StRefreshCheck,                      // last of the three refresh NOPs
		StLoadMode,
		StModeNop,
		StIdle
	} initState_t;

endpackage

`default_nettype wire

//--- verilog/InitTimer.sv
// Init Down Counter
`timescale 1ns/1ps
`default_nettype none

`include "sdram_defines.svh"

module InitTimer (
	input  wire logic                    Clock,
	input  wire logic                    Reset_L,
	input  wire logic                    load,     // load value on next edge
	input  wire logic [`TIMER_WIDTH-1:0] value,
	output logic                         done      // count sits at zero
);

	logic [`TIMER_WIDTH-1:0] count;

	//////////////////////////////////////////////////
	// count down and stop at zero
	//////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			count <= '0;                                  // expired after reset
		end else if (load) begin
			count <= value;                               // load wins over decrement
		end else if (count != '0) begin
			count <= count - `TIMER_WIDTH'd1;             // saturates at zero
		end
	end

	assign done = (count == '0);                          // straight from the count

endmodule

`default_nettype wire

//--- verilog/InitSequencer.sv
// SDRAM Init State Machine
`timescale 1ns/1ps
`default_nettype none

`include "sdram_defines.svh"

module InitSequencer import SdramPkg::*; (
	input  wire logic                    Clock,
	input  wire logic                    Reset_L,
	input  wire logic                    timerDone,   // timer at zero
	output logic                         timerLoad,   // one-cycle load pulse
	output logic [`TIMER_WIDTH-1:0]      timerValue,
	output cmdKind_t                     kind,        // command for the next cycle
	output logic                         releaseCpu   // high only in idle
);

	initState_t state;
	initState_t nextState;

	//////////////////////////////////////////////////
	// state register
	//////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= StInitialising;
		end else begin
			state <= nextState;
		end
	end

	//////////////////////////////////////////////////
	// next state and command choice
	//////////////////////////////////////////////////
	always_comb begin
		nextState  = state;                              // hold by default
		timerLoad  = 1'b0;
		timerValue = '0;
		kind       = CmdNop;                             // most states issue NOP
		releaseCpu = 1'b0;

		unique case (state)
			StInitialising: begin
				kind       = CmdPowerUp;                 // cke and cs low
				timerLoad  = 1'b1;                       // start power-up delay
				timerValue = `TIMER_WIDTH'(`POWER_UP_CYCLES);
				nextState  = StWaitPowerUp;
			end

			StWaitPowerUp: begin
				kind = CmdPowerUp;
				if (timerDone) begin                     // delay elapsed
					nextState = StFirstNop;
				end
			end

			StFirstNop: begin
				nextState = StPrechargeAll;              // first command with cke high
			end

			StPrechargeAll: begin
				kind      = CmdPrechargeAll;             // A10 set in command issue
				nextState = StSecondNop;
			end

			StSecondNop: begin
				timerLoad  = 1'b1;                       // open the refresh window
				timerValue = `TIMER_WIDTH'(`REFRESH_WINDOW);
				nextState  = StRefresh;
			end

			StRefresh: begin
				kind      = CmdAutoRefresh;
				nextState = StRefreshNopA;
			end

			StRefreshNopA: begin
				nextState = StRefreshNopB;
			end

			StRefreshNopB: begin
				nextState = StRefreshCheck;
			end

			StRefreshCheck: begin
				if (timerDone) begin                     // window closed
					nextState = StLoadMode;
				end else begin
					nextState = StRefresh;               // another pass of four cycles
				end
			end

			StLoadMode: begin
				kind      = CmdModeSet;
				nextState = StModeNop;
			end

			StModeNop: begin
				nextState = StIdle;
			end

			StIdle: begin
				releaseCpu = 1'b1;                       // let the CPU run
			end

			default: begin
				nextState = StInitialising;              // unused encodings restart
			end
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/CommandIssue.sv
// SDRAM Command Pin Driver
`timescale 1ns/1ps
`default_nettype none

`include "sdram_defines.svh"

module CommandIssue import SdramPkg::*; (
	input  wire logic     Clock,
	input  wire logic     Reset_L,
	input  wire cmdKind_t kind,           // requested command
	input  wire logic     releaseCpu,     // idle reached
	output sdramBus_t     SdramBus,       // registered pins
	output logic          ResetOut_L      // registered CPU reset
);

	// cke csL rasL casL weL
	localparam sdramCmd_t PinsPowerUp  = 5'b00000;   // everything low
	localparam sdramCmd_t PinsNop      = 5'b10111;
	localparam sdramCmd_t PinsPrecharge = 5'b10010;
	localparam sdramCmd_t PinsRefresh  = 5'b10001;
	localparam sdramCmd_t PinsModeSet  = 5'b10000;

	sdramBus_t nextBus;

	//////////////////////////////////////////////////
	// command decode
	//////////////////////////////////////////////////
	always_comb begin
		nextBus = '0;                                    // ba and address zero
		unique case (kind)
			CmdPowerUp: nextBus.cmd = PinsPowerUp;
			CmdNop:     nextBus.cmd = PinsNop;
			CmdPrechargeAll: begin
				nextBus.cmd = PinsPrecharge;
				nextBus.addr.row[`PRECHARGE_ALL_BIT] = 1'b1;   // all banks
			end
			CmdAutoRefresh: nextBus.cmd = PinsRefresh;
			CmdModeSet: begin
				nextBus.cmd                  = PinsModeSet;
				nextBus.ba                   = '0;             // base mode register
				nextBus.addr.mode.reserved   = '0;
				nextBus.addr.mode.writeBurst = 1'(`MODE_WRITE_BURST);
				nextBus.addr.mode.opMode     = '0;             // standard operation
				nextBus.addr.mode.casLatency = 3'(`MODE_CAS_LATENCY);
				nextBus.addr.mode.burstType  = 1'(`MODE_BURST_TYPE);
				nextBus.addr.mode.burstLength = 3'(`MODE_BURST_LENGTH);
			end
			default: nextBus.cmd = PinsNop;
		endcase
	end

	//////////////////////////////////////////////////
	// output registers
	//////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			SdramBus   <= '0;                            // power-up levels
			ResetOut_L <= 1'b0;                          // hold CPU in reset
		end else begin
			SdramBus   <= nextBus;                       // one cycle behind the state
			ResetOut_L <= releaseCpu;
		end
	end

endmodule

`default_nettype wire

//--- verilog/SdramInitController.sv
// SDRAM Init Controller Top
`timescale 1ns/1ps
`default_nettype none

`include "sdram_defines.svh"

module SdramInitController import SdramPkg::*; (
	input  wire logic Clock,
	input  wire logic Reset_L,          // asynchronous, active low
	output sdramBus_t SdramBus,         // pins to the SDRAM
	output logic      ResetOut_L        // reset to the CPU
);

	logic                    timerDone;     // timer back to the FSM
	logic                    timerLoad;
	logic [`TIMER_WIDTH-1:0] timerValue;
	cmdKind_t                kind;          // FSM to pin driver
	logic                    releaseCpu;

	InitSequencer sequencer (
		.Clock      (Clock),
		.Reset_L    (Reset_L),
		.timerDone  (timerDone),
		.timerLoad  (timerLoad),
		.timerValue (timerValue),
		.kind       (kind),
		.releaseCpu (releaseCpu)
	);

	InitTimer initTimer (
		.Clock   (Clock),
		.Reset_L (Reset_L),
		.load    (timerLoad),
		.value   (timerValue),
		.done    (timerDone)
	);

	CommandIssue commandIssue (
		.Clock      (Clock),
		.Reset_L    (Reset_L),
		.kind       (kind),
		.releaseCpu (releaseCpu),
		.SdramBus   (SdramBus),
		.ResetOut_L (ResetOut_L)
	);

endmodule

`default_nettype wire

//--- bench/sdramInit_sva.sv
// SDRAM Init Assertions
`timescale 1ns/1ps
`default_nettype none

module SdramInitSva import SdramPkg::*; (
	input wire logic      Clock,
	input wire logic      Reset_L,
	input wire sdramBus_t SdramBus,
	input wire logic      ResetOut_L
);

	// cke csL rasL casL weL, from the SDRAM command truth table
	localparam sdramCmd_t NopPins       = 5'b10111;
	localparam sdramCmd_t PrechargePins = 5'b10010;
	localparam sdramCmd_t RefreshPins   = 5'b10001;
	localparam sdramCmd_t ModePins      = 5'b10000;

	logic prechargeSeen;                                  // a precharge has been on the pins

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			prechargeSeen <= 1'b0;
		end else if (SdramBus.cmd == PrechargePins) begin
			prechargeSeen <= 1'b1;                        // sticks until reset
		end
	end

	ckeStaysHigh: assert property (@(posedge Clock) disable iff (!Reset_L)
		!$fell(SdramBus.cmd.cke)) else $error("cke fell after going high");

	cpuResetStaysHigh: assert property (@(posedge Clock) disable iff (!Reset_L)
		!$fell(ResetOut_L)) else $error("ResetOut_L fell after release");

	refreshThreeNops: assert property (@(posedge Clock) disable iff (!Reset_L)
		(SdramBus.cmd == RefreshPins) |=> (SdramBus.cmd == NopPins) [*3])
		else $error("auto refresh not followed by three NOPs");

	modeAfterPrecharge: assert property (@(posedge Clock) disable iff (!Reset_L)
		(SdramBus.cmd == ModePins) |-> prechargeSeen)
		else $error("mode set issued before any precharge all");

endmodule

bind SdramInitController SdramInitSva sva (
	.Clock      (Clock),
	.Reset_L    (Reset_L),
	.SdramBus   (SdramBus),
	.ResetOut_L (ResetOut_L)
);

`default_nettype wire

//--- bench/SdramInitTb.sv
// SDRAM Init Testbench
`timescale 1ns/1ps
`default_nettype none

`include "sdram_defines.svh"

module SdramInitTb import SdramPkg::*; ();

	localparam int WatchdogNs = (`POWER_UP_CYCLES + `REFRESH_WINDOW + 64) * 8 * 2;

	logic      Clock = 1'b0;                              // no edge at time zero
	logic      Reset_L;
	sdramBus_t SdramBus;
	logic      ResetOut_L;

	int   errorCount  = 0;
	int   testErrors  = 0;                                // errors when the current test began
	int   testsRun    = 0;
	int   testsFailed = 0;
	logic monitorDone = 1'b0;

	SdramInitController dut (
		.Clock      (Clock),
		.Reset_L    (Reset_L),
		.SdramBus   (SdramBus),
		.ResetOut_L (ResetOut_L)
	);

	always #4 Clock = ~Clock;                             // 8 ns period

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////
	function automatic sdramBus_t expectedBus(input cmdKind_t k);
		sdramBus_t b;
		b = '0;                                           // ba and address zero unless set
		case (k)
			CmdPowerUp: b.cmd = '0;                       // every pin low
			CmdNop: begin
				b.cmd.cke  = 1'b1;                        // cs low, strobes high
				b.cmd.rasL = 1'b1;
				b.cmd.casL = 1'b1;
				b.cmd.weL  = 1'b1;
			end
			CmdPrechargeAll: begin
				b.cmd.cke  = 1'b1;
				b.cmd.casL = 1'b1;                        // ras and we low
				b.addr.row = `ROW_WIDTH'(1) << `PRECHARGE_ALL_BIT;
			end
			CmdAutoRefresh: begin
				b.cmd.cke = 1'b1;
				b.cmd.weL = 1'b1;                         // ras and cas low
			end
			CmdModeSet: begin
				b.cmd.cke                = 1'b1;          // all strobes low
				b.addr.mode.writeBurst   = 1'(`MODE_WRITE_BURST);
				b.addr.mode.casLatency   = 3'(`MODE_CAS_LATENCY);
				b.addr.mode.burstType    = 1'(`MODE_BURST_TYPE);
				b.addr.mode.burstLength  = 3'(`MODE_BURST_LENGTH);
			end
			default: b = 'x;
		endcase
		return b;
	endfunction

	// n-th check reads window - 3 - 4(n-1) and the pass whose check reads zero also refreshes
	function automatic int expectedRefreshes();
		return ((`REFRESH_WINDOW - 3) + 3) / 4 + 1;       // checks finding it open, plus the last
	endfunction

	//////////////////////////////////////////////////
	// compare tasks and test bookkeeping
	//////////////////////////////////////////////////
	task automatic checkCmd(input sdramCmd_t got, input sdramCmd_t exp, input string name);
		if (got !== exp) begin
			errorCount++;
			$display("Error %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkAddr(input sdramAddr_u got, input sdramAddr_u exp, input string name);
		if (got !== exp) begin
			errorCount++;
			$display("Error %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkCount(input int got, input int exp, input string name);
		if (got != exp) begin
			errorCount++;
			$display("Error %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkPins(input cmdKind_t k);
		sdramBus_t exp;
		exp = expectedBus(k);
		checkCmd(SdramBus.cmd, exp.cmd, "SdramBus.cmd");
		checkCount(int'(SdramBus.ba), int'(exp.ba), "SdramBus.ba");
		checkAddr(SdramBus.addr, exp.addr, "SdramBus.addr");
	endtask

	task automatic closeTest(input string name);
		testsRun++;
		if (errorCount != testErrors) begin
			testsFailed++;
			$display("%s: FAILED with %0d errors", name, errorCount - testErrors);
		end else begin
			$display("%s: ok", name);
		end
		testErrors = errorCount;                          // next test starts clean
	endtask

	//////////////////////////////////////////////////
	// monitor, sampled mid-cycle on the falling edge
	//////////////////////////////////////////////////
	initial begin : monitor
		int        powerUpCycles;
		int        refreshes;
		sdramBus_t refreshPins;
		refreshPins = expectedBus(CmdAutoRefresh);
		@(negedge Clock);
		while (!Reset_L) begin                            // reset levels
			checkPins(CmdPowerUp);
			checkCount(int'(ResetOut_L), 0, "ResetOut_L");
			@(negedge Clock);
		end
		closeTest("reset levels");
		powerUpCycles = 0;
		while (SdramBus === expectedBus(CmdPowerUp)) begin
			powerUpCycles++;
			checkCount(int'(ResetOut_L), 0, "ResetOut_L");
			@(negedge Clock);
		end
		if (powerUpCycles < `POWER_UP_CYCLES + 1) begin
			errorCount++;
			$display("power-up hold lasted only %0d cycles", powerUpCycles);
		end
		checkPins(CmdNop);                                // first change is a NOP
		closeTest("power-up hold");
		@(negedge Clock);
		checkPins(CmdPrechargeAll);                       // A10 set in the row view
		@(negedge Clock);
		checkPins(CmdNop);                                // NOP before the first refresh
		closeTest("precharge all");
		refreshes = 0;
		@(negedge Clock);
		while (SdramBus.cmd === refreshPins.cmd) begin
			refreshes++;
			checkPins(CmdAutoRefresh);
			repeat (3) begin
				@(negedge Clock);
				checkPins(CmdNop);
			end
			@(negedge Clock);
		end
		checkCount(refreshes, expectedRefreshes(), "refresh count");
		closeTest("refresh loop");
		checkPins(CmdModeSet);                            // mode view and ba zero
		checkCount(int'(ResetOut_L), 0, "ResetOut_L");
		closeTest("mode register load");
		@(negedge Clock);
		checkPins(CmdNop);
		checkCount(int'(ResetOut_L), 0, "ResetOut_L");    // one cycle after mode set
		@(negedge Clock);
		checkPins(CmdNop);
		checkCount(int'(ResetOut_L), 1, "ResetOut_L");    // released two cycles after
		repeat (32) begin
			@(negedge Clock);
			checkPins(CmdNop);
			checkCount(int'(ResetOut_L), 1, "ResetOut_L");
		end
		closeTest("cpu release and idle");
		monitorDone = 1'b1;
	end

	//////////////////////////////////////////////////
	// reset, report and watchdog
	//////////////////////////////////////////////////
	initial begin
		Reset_L = 1'b0;
		repeat (4) @(posedge Clock);
		Reset_L <= 1'b1;                                  // release on a rising edge
		wait (monitorDone);
		$display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
		if (errorCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#(WatchdogNs);
		$display("Timeout: the initialisation sequence did not complete in time");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+verilog
verilog/SdramPkg.sv
verilog/InitTimer.sv
verilog/InitSequencer.sv
verilog/CommandIssue.sv
verilog/SdramInitController.sv
bench/sdramInit_sva.sv
bench/SdramInitTb.sv

//--- Bender.yml
package:
  name: sdram_init_controller

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/SdramPkg.sv
      - verilog/InitTimer.sv
      - verilog/InitSequencer.sv
      - verilog/CommandIssue.sv
      - verilog/SdramInitController.sv
      - target: test
        files:
          - bench/sdramInit_sva.sv
          - bench/SdramInitTb.sv
